//--- compile.f
rob_pkg.sv
rename_dispatch.sv
rob.sv
retire_unit.sv
ooo_retire_top.sv
tb_ooo_retire.sv

//--- ooo_retire_top.sv
module ooo_retire_top
    import rob_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  dispatch_pkt_t [DISPATCH_WIDTH-1:0]            decode_in,
    input  complete_pkt_t [COMPLETE_PORTS-1:0]            complete_in,
    input  areg_t                                         arch_raddr,
    output logic                                          dispatch_stall,
    output logic          [DISPATCH_WIDTH-1:0]            alloc_valid,
    output logic          [DISPATCH_WIDTH-1:0][ROB_ADDR_W-1:0] alloc_addr,
    output retire_pkt_t   [RETIRE_WIDTH-1:0]              retire_out,
    output logic                                          flush,
    output xlen_t                                         epc,
    output xlen_t                                         arch_rdata
);

    dispatch_pkt_t [DISPATCH_WIDTH-1:0] disp_pkt;
    retire_pkt_t   [RETIRE_WIDTH-1:0]   retire_pkt;
    logic                               rob_ready;

    rename_dispatch u_dispatch (
        .clk            (clk),
        .rst_n          (rst_n),
        .decode_in      (decode_in),
        .rob_ready      (rob_ready),
        .flush          (flush),
        .disp_pkt       (disp_pkt),
        .dispatch_stall (dispatch_stall)
    );

    rob u_rob (
        .clk         (clk),
        .rst_n       (rst_n),
        .disp_pkt    (disp_pkt),
        .complete_in (complete_in),
        .flush       (flush),
        .rob_ready   (rob_ready),
        .alloc_valid (alloc_valid),
        .alloc_addr  (alloc_addr),
        .retire_pkt  (retire_pkt)
    );

    retire_unit u_retire (
        .clk        (clk),
        .rst_n      (rst_n),
        .retire_pkt (retire_pkt),
        .arch_raddr (arch_raddr),
        .flush      (flush),
        .epc        (epc),
        .arch_rdata (arch_rdata)
    );

    assign retire_out = retire_pkt;

endmodule

//--- rename_dispatch.sv
module rename_dispatch
    import rob_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  dispatch_pkt_t [DISPATCH_WIDTH-1:0] decode_in,
    input  logic                               rob_ready,
    input  logic                               flush,
    output dispatch_pkt_t [DISPATCH_WIDTH-1:0] disp_pkt,
    output logic                               dispatch_stall
);

    dispatch_pkt_t [DISPATCH_WIDTH-1:0] held_q;
    dispatch_pkt_t [DISPATCH_WIDTH-1:0] compact_in;
    logic                               held_any;
    logic                               load;

    // squeeze valid lanes toward lane 0 so the buffer fills in order
    always_comb begin
        int unsigned slot;
        compact_in = '0;
        slot = 0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (decode_in[i].valid) begin
                compact_in[slot] = decode_in[i];
                slot = slot + 1;
            end
        end
    end

    always_comb begin
        held_any = 1'b0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            held_any = held_any | held_q[i].valid;
        end
    end

    // held pair leaves whenever the buffer has room
    assign load           = !held_any || rob_ready;
    assign dispatch_stall = held_any && !rob_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q <= '0;
        end else if (flush) begin
            held_q <= '0;
        end else if (load) begin
            held_q <= compact_in;
        end
    end

    assign disp_pkt = held_q;

    a_lane_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        disp_pkt[1].valid |-> disp_pkt[0].valid
    ) else $error("lane 1 valid without lane 0 on disp_pkt");

endmodule

//--- retire_unit.sv
module retire_unit
    import rob_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  retire_pkt_t [RETIRE_WIDTH-1:0]  retire_pkt,
    input  areg_t                           arch_raddr,
    output logic                            flush,
    output xlen_t                           epc,
    output xlen_t                           arch_rdata
);

    xlen_t arf [NUM_AREGS];
    logic  excp_hit;
    xlen_t excp_pc;

    // pick up a faulting lane, lowest lane first
    always_comb begin
        excp_hit = 1'b0;
        excp_pc  = '0;
        for (int i = RETIRE_WIDTH - 1; i >= 0; i--) begin
            if (retire_pkt[i].valid && retire_pkt[i].excp) begin
                excp_hit = 1'b1;
                excp_pc  = retire_pkt[i].pc;
            end
        end
    end

    // later lane is younger, so it overrides a shared dst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_AREGS; r++) begin
                arf[r] <= '0;
            end
        end else begin
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (retire_pkt[i].valid && !retire_pkt[i].excp && retire_pkt[i].dst != '0) begin
                    arf[retire_pkt[i].dst] <= retire_pkt[i].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush <= 1'b0;
            epc   <= '0;
        end else begin
            flush <= excp_hit && !flush;
            if (excp_hit && !flush) begin
                epc <= excp_pc;
            end
        end
    end

    // r0 is never written
    assign arch_rdata = arf[arch_raddr];

    a_flush_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !flush
    ) else $error("flush held for more than one cycle");

    // the buffer must stay silent during the flush cycle
    for (genvar i = 0; i < RETIRE_WIDTH; i++) begin : g_quiet_chk
        a_no_retire_in_flush: assert property (
            @(posedge clk) disable iff (!rst_n)
            flush |-> !(retire_pkt[i].valid && !retire_pkt[i].excp)
        ) else $error("retirement on lane %0d during flush", i);
    end

endmodule

//--- rob.sv
module rob
    import rob_pkg::*;
(
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  dispatch_pkt_t [DISPATCH_WIDTH-1:0]            disp_pkt,
    input  complete_pkt_t [COMPLETE_PORTS-1:0]            complete_in,
    input  logic                                          flush,
    output logic                                          rob_ready,
    output logic          [DISPATCH_WIDTH-1:0]            alloc_valid,
    output logic          [DISPATCH_WIDTH-1:0][ROB_ADDR_W-1:0] alloc_addr,
    output retire_pkt_t   [RETIRE_WIDTH-1:0]              retire_pkt
);

    rob_entry_t [ROB_DEPTH-1:0] rob_tbl;

    rob_ptr_t  head_ptr;
    rob_ptr_t  tail_ptr;
    rob_ptr_t  used;
    rob_addr_t head_addr;
    rob_addr_t tail_addr;
    logic      empty;

    logic [$clog2(RETIRE_WIDTH+1)-1:0]   retire_cnt;
    logic [$clog2(DISPATCH_WIDTH+1)-1:0] alloc_cnt;

    assign head_addr = head_ptr[ROB_ADDR_W-1:0];
    assign tail_addr = tail_ptr[ROB_ADDR_W-1:0];

    // pointer distance, the wrap bit keeps full apart from empty
    assign used  = tail_ptr - head_ptr;
    assign empty = (head_ptr == tail_ptr);

    // room for a whole dispatch pair
    assign rob_ready = (used <= rob_ptr_t'(ROB_DEPTH - 2));

    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            alloc_valid[i] = disp_pkt[i].valid && rob_ready && !flush;
            alloc_addr[i]  = tail_addr + rob_addr_t'(i);
            if (alloc_valid[i]) begin
                alloc_cnt = alloc_cnt + 1'b1;
            end
        end
    end

    // oldest finished entries, stop at the first unfinished one
    always_comb begin
        logic      stop;
        rob_addr_t idx;
        retire_pkt = '0;
        retire_cnt = '0;
        stop       = flush || empty;
        for (int i = 0; i < RETIRE_WIDTH; i++) begin
            idx = head_addr + rob_addr_t'(i);
            if (!stop && (rob_tbl[idx].state == ST_DONE || rob_tbl[idx].state == ST_EXCP)) begin
                retire_pkt[i].valid = 1'b1;
                retire_pkt[i].excp  = (rob_tbl[idx].state == ST_EXCP);
                retire_pkt[i].dst   = rob_tbl[idx].dst;
                retire_pkt[i].data  = rob_tbl[idx].data;
                retire_pkt[i].pc    = rob_tbl[idx].pc;
                if (rob_tbl[idx].state == ST_EXCP) begin
                    // faulting entry stays put until the flush
                    stop = 1'b1;
                end else begin
                    retire_cnt = retire_cnt + 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rob_tbl  <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else if (flush) begin
            for (int j = 0; j < ROB_DEPTH; j++) begin
                rob_tbl[j].state <= ST_FREE;
            end
            tail_ptr <= head_ptr;
        end else begin
            // free retired entries
            for (int i = 0; i < RETIRE_WIDTH; i++) begin
                if (retire_pkt[i].valid && !retire_pkt[i].excp) begin
                    rob_tbl[head_addr + rob_addr_t'(i)].state <= ST_FREE;
                end
            end
            // completions only hit waiting entries, no overlap with the above
            for (int p = 0; p < COMPLETE_PORTS; p++) begin
                if (complete_in[p].valid) begin
                    rob_tbl[complete_in[p].rob_addr].data  <= complete_in[p].data;
                    rob_tbl[complete_in[p].rob_addr].state <=
                        complete_in[p].exception ? ST_EXCP : ST_DONE;
                end
            end
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (alloc_valid[i]) begin
                    rob_tbl[alloc_addr[i]].state <= ST_WAIT;
                    rob_tbl[alloc_addr[i]].dst   <= disp_pkt[i].dst;
                    rob_tbl[alloc_addr[i]].pc    <= disp_pkt[i].pc;
                end
            end
            head_ptr <= head_ptr + rob_ptr_t'(retire_cnt);
            tail_ptr <= tail_ptr + rob_ptr_t'(alloc_cnt);
        end
    end

    for (genvar p = 0; p < COMPLETE_PORTS; p++) begin : g_cmp_chk
        a_cmp_wait: assert property (
            @(posedge clk) disable iff (!rst_n)
            complete_in[p].valid && !flush |-> rob_tbl[complete_in[p].rob_addr].state == ST_WAIT
        ) else $error("completion on port %0d to entry not waiting", p);
    end

    // a write must land on a free slot, which only holds while there is room
    a_write_room: assert property (
        @(posedge clk) disable iff (!rst_n)
        |alloc_valid |-> rob_ready && rob_tbl[tail_addr].state == ST_FREE
    ) else $error("buffer write without room");

    a_excp_block: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_pkt[0].valid && retire_pkt[0].excp
            |-> !retire_pkt[1].valid ##1 head_ptr == $past(head_ptr)
    ) else $error("retirement passed an exception entry");

endmodule

//--- rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH  = 16;
    localparam int ROB_ADDR_W = 4;
    // extra msb is the wrap bit
    localparam int ROB_PTR_W  = 5;

    // lanes
    localparam int DISPATCH_WIDTH = 2;
    localparam int RETIRE_WIDTH   = 2;
    localparam int COMPLETE_PORTS = 2;

    // architectural state
    localparam int NUM_AREGS = 32;
    localparam int AREG_W    = 5;
    localparam int XLEN      = 32;

    typedef logic [ROB_ADDR_W-1:0] rob_addr_t;
    typedef logic [ROB_PTR_W-1:0]  rob_ptr_t;
    typedef logic [AREG_W-1:0]     areg_t;
    typedef logic [XLEN-1:0]       xlen_t;

    // entry life cycle, free must stay zero
    typedef enum logic [1:0] {
        ST_FREE = 2'd0,
        ST_WAIT = 2'd1,
        ST_DONE = 2'd2,
        ST_EXCP = 2'd3
    } entry_state_e;

    // decoded instruction from the front end
    typedef struct packed {
        logic  valid;
        areg_t dst;
        xlen_t pc;
    } dispatch_pkt_t;

    // result from an execution unit
    typedef struct packed {
        logic      valid;
        rob_addr_t rob_addr;
        xlen_t     data;
        logic      exception;
    } complete_pkt_t;

    // instruction leaving the buffer in program order
    typedef struct packed {
        logic  valid;
        logic  excp;
        areg_t dst;
        xlen_t data;
        xlen_t pc;
    } retire_pkt_t;

    // one table slot
    typedef struct packed {
        entry_state_e state;
        areg_t        dst;
        xlen_t        data;
        xlen_t        pc;
    } rob_entry_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_retire -f compile.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_ooo_retire)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "run passed" || { echo "run failed"; exit 1; }

//--- tb_ooo_retire.sv
module tb_ooo_retire
    import rob_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        rob_addr_t addr;
        areg_t     dst;
        xlen_t     pc;
    } order_rec_t;

    logic                                      clk;
    logic                                      rst_n;
    dispatch_pkt_t [DISPATCH_WIDTH-1:0]        decode_in;
    complete_pkt_t [COMPLETE_PORTS-1:0]        complete_in;
    areg_t                                     arch_raddr;
    logic                                      dispatch_stall;
    logic [DISPATCH_WIDTH-1:0]                 alloc_valid;
    logic [DISPATCH_WIDTH-1:0][ROB_ADDR_W-1:0] alloc_addr;
    retire_pkt_t [RETIRE_WIDTH-1:0]            retire_out;
    logic                                      flush;
    xlen_t                                     epc;
    xlen_t                                     arch_rdata;

    int        seed         = 48;
    int        mismatch_cnt = 0;
    int        timeout_cnt  = 0;
    int        retired_cnt  = 0;
    int        flush_cnt    = 0;
    int        outstanding  = 0;
    int        pc_seq       = 0;
    bit        stall_seen   = 1'b0;
    bit        excp_pending = 1'b0;
    xlen_t     excp_pc_q    = '0;
    areg_t     probe_reg    = '0;
    rob_addr_t exp_head     = '0;
    rob_addr_t exp_tail     = '0;

    // model: instructions sent but not yet allocated, then program order
    dispatch_pkt_t sent_q[$];
    order_rec_t    order_q[$];
    // 0 waiting, 1 done, 2 exception
    logic [1:0]    done_st [ROB_DEPTH];
    xlen_t         comp_data [ROB_DEPTH];
    xlen_t         shadow_rf [NUM_AREGS];

    ooo_retire_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .decode_in      (decode_in),
        .complete_in    (complete_in),
        .arch_raddr     (arch_raddr),
        .dispatch_stall (dispatch_stall),
        .alloc_valid    (alloc_valid),
        .alloc_addr     (alloc_addr),
        .retire_out     (retire_out),
        .flush          (flush),
        .epc            (epc),
        .arch_rdata     (arch_rdata)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string msg);
        mismatch_cnt++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        timeout_cnt++;
        $display("timed out waiting for %s", what);
    endtask

    function automatic dispatch_pkt_t new_insn(input areg_t dst);
        dispatch_pkt_t p;
        p.valid = 1'b1;
        p.dst   = dst;
        p.pc    = 32'h0000_1000 + xlen_t'(pc_seq * 4);
        pc_seq++;
        return p;
    endfunction

    task automatic send_pair(input dispatch_pkt_t a, input dispatch_pkt_t b);
        int waited;
        waited = 0;
        @(negedge clk);
        while (dispatch_stall && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (dispatch_stall) begin
            report_timeout("dispatch_stall to drop");
            decode_in = '0;
        end else begin
            decode_in[0] = a;
            decode_in[1] = b;
            if (a.valid) sent_q.push_back(a);
            if (b.valid) sent_q.push_back(b);
        end
    endtask

    task automatic send_insns(input int n);
        int            left;
        int            r;
        dispatch_pkt_t a;
        left = n;
        while (left > 0) begin
            r = $random(seed);
            a = new_insn(areg_t'(r[9:5]));
            if (left == 1 || r[2:0] == 3'd0) begin
                // lone lane 1 instruction, dispatch must move it to lane 0
                send_pair('0, a);
                left = left - 1;
            end else begin
                send_pair(a, new_insn(r[3] ? a.dst : areg_t'(r[14:10])));
                left = left - 2;
            end
        end
        @(negedge clk);
        decode_in = '0;
    endtask

    // plays the execution units, random order, faulting entry held back to the end
    task automatic complete_pending(input int count, input bit with_fault, input xlen_t fault_pc);
        int driven;
        int waited;
        int pick;
        int cand[$];
        driven = 0;
        waited = 0;
        while (driven < count && waited < 400) begin
            @(negedge clk);
            complete_in = '0;
            cand.delete();
            foreach (order_q[k]) begin
                if (done_st[order_q[k].addr] == 2'd0 && !(with_fault &&
                        order_q[k].pc == fault_pc && driven < count - 1)) begin
                    cand.push_back(k);
                end
            end
            for (int p = 0; p < COMPLETE_PORTS; p++) begin
                if (cand.size() > 0 && driven < count) begin
                    pick = $unsigned($random(seed)) % cand.size();
                    complete_in[p].valid     = 1'b1;
                    complete_in[p].rob_addr  = order_q[cand[pick]].addr;
                    complete_in[p].data      = $random(seed);
                    complete_in[p].exception = with_fault && order_q[cand[pick]].pc == fault_pc;
                    cand.delete(pick);
                    driven++;
                end
            end
            waited++;
        end
        if (driven < count) report_timeout("all completions to be issued");
        @(negedge clk);
        complete_in = '0;
    endtask

    task automatic wait_stall();
        int waited;
        waited = 0;
        while (!dispatch_stall && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!dispatch_stall) report_timeout("dispatch_stall to rise");
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((order_q.size() > 0 || sent_q.size() > 0) && waited < 400) begin
            @(negedge clk);
            waited++;
        end
        if (order_q.size() > 0 || sent_q.size() > 0) report_timeout("the buffer to drain");
    endtask

    // register file probe follows the latest retirement, otherwise sweeps
    initial begin
        arch_raddr = '0;
        forever begin
            @(negedge clk);
            arch_raddr = probe_reg;
        end
    end

    always @(posedge clk) begin
        order_rec_t e;
        bit         stop;
        bit         moved;
        if (rst_n) begin
            assert (arch_rdata === shadow_rf[arch_raddr] && (arch_raddr != 0 || arch_rdata == 0))
                else report_mismatch($sformatf("r%0d reads %h, expected %h",
                    arch_raddr, arch_rdata, shadow_rf[arch_raddr]));
            assert (flush === excp_pending)
                else report_mismatch($sformatf("flush is %b, expected %b", flush, excp_pending));
            assert (!excp_pending || epc === excp_pc_q)
                else report_mismatch($sformatf("epc %h, expected %h", epc, excp_pc_q));
            excp_pending = 1'b0;
            moved = 1'b0;
            if (dispatch_stall) stall_seen = 1'b1;
            if (flush) begin
                flush_cnt++;
                order_q.delete();
                sent_q.delete();
                foreach (done_st[j]) done_st[j] = 2'd0;
                exp_tail = exp_head;
            end else begin
                stop = 1'b0;
                for (int i = 0; i < RETIRE_WIDTH; i++) begin
                    if (!stop && order_q.size() > 0 && done_st[order_q[0].addr] != 2'd0) begin
                        e = order_q[0];
                        assert (retire_out[i].valid && retire_out[i].pc === e.pc &&
                                retire_out[i].dst === e.dst)
                            else report_mismatch($sformatf("lane %0d shows pc %h, expected pc %h",
                                i, retire_out[i].pc, e.pc));
                        if (done_st[e.addr] == 2'd2) begin
                            assert (retire_out[i].excp)
                                else report_mismatch($sformatf("pc %h lost its exception", e.pc));
                            excp_pending = 1'b1;
                            excp_pc_q = e.pc;
                            stop = 1'b1;
                        end else begin
                            assert (!retire_out[i].excp && retire_out[i].data === comp_data[e.addr])
                                else report_mismatch($sformatf("pc %h retired data %h, expected %h",
                                    e.pc, retire_out[i].data, comp_data[e.addr]));
                            if (e.dst != '0) shadow_rf[e.dst] = comp_data[e.addr];
                            probe_reg = e.dst;
                            moved = 1'b1;
                            done_st[e.addr] = 2'd0;
                            order_q.pop_front();
                            exp_head++;
                            retired_cnt++;
                        end
                    end else begin
                        stop = 1'b1;
                        assert (!retire_out[i].valid)
                            else report_mismatch($sformatf("lane %0d retired an unfinished entry", i));
                    end
                end
                for (int p = 0; p < COMPLETE_PORTS; p++) begin
                    if (complete_in[p].valid) begin
                        done_st[complete_in[p].rob_addr] = complete_in[p].exception ? 2'd2 : 2'd1;
                        comp_data[complete_in[p].rob_addr] = complete_in[p].data;
                    end
                end
                for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                    if (alloc_valid[i]) begin
                        assert (sent_q.size() > 0 && alloc_addr[i] == exp_tail)
                            else report_mismatch($sformatf("lane %0d allocated entry %0d, expected %0d",
                                i, alloc_addr[i], exp_tail));
                        if (sent_q.size() > 0) begin
                            e.addr = exp_tail;
                            e.dst  = sent_q[0].dst;
                            e.pc   = sent_q[0].pc;
                            order_q.push_back(e);
                            sent_q.pop_front();
                        end
                        exp_tail++;
                    end
                end
            end
            outstanding = order_q.size();
            if (!moved) probe_reg = probe_reg + 1'b1;
        end
    end

    a_flush_once: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !flush)
        else report_mismatch("flush lasted more than one cycle");

    a_rob_bound: assert property (@(posedge clk) disable iff (!rst_n) outstanding <= ROB_DEPTH)
        else report_mismatch($sformatf("%0d entries outstanding", outstanding));

    a_lane_pair: assert property (@(posedge clk) disable iff (!rst_n)
        retire_out[1].valid |-> retire_out[0].valid)
        else report_mismatch("lane 1 retired without lane 0");

    initial begin
        int    base;
        int    base_flush;
        xlen_t fault_pc;
        clk         = 1'b0;
        rst_n       = 1'b0;
        decode_in   = '0;
        complete_in = '0;
        foreach (shadow_rf[r]) shadow_rf[r] = '0;
        foreach (done_st[j]) begin
            done_st[j]   = 2'd0;
            comp_data[j] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset, probe sweeps every register
        @(negedge clk);
        assert (!dispatch_stall && !flush && alloc_valid == '0 &&
                !retire_out[0].valid && !retire_out[1].valid && arch_rdata == '0)
            else report_mismatch("outputs not idle after reset");
        repeat (NUM_AREGS) @(negedge clk);

        // out of order completion, in order retirement
        base = retired_cnt;
        send_insns(8);
        complete_pending(8, 1'b0, '0);
        wait_drained();
        assert (retired_cnt - base == 8)
            else report_mismatch($sformatf("%0d of 8 retired", retired_cnt - base));

        // r0 writes and shared destinations
        base = retired_cnt;
        send_pair(new_insn(5'd0), new_insn(5'd0));
        send_pair(new_insn(5'd9), new_insn(5'd9));
        send_pair(new_insn(5'd0), new_insn(5'd9));
        @(negedge clk);
        decode_in = '0;
        complete_pending(6, 1'b0, '0);
        wait_drained();
        assert (retired_cnt - base == 6)
            else report_mismatch($sformatf("%0d of 6 retired", retired_cnt - base));

        // fill the buffer before any completion
        base = retired_cnt;
        stall_seen = 1'b0;
        fork
            send_insns(20);
            begin
                wait_stall();
                complete_pending(20, 1'b0, '0);
            end
        join
        wait_drained();
        assert (stall_seen) else report_mismatch("dispatch_stall never rose on a full buffer");
        assert (retired_cnt - base == 20)
            else report_mismatch($sformatf("%0d of 20 retired", retired_cnt - base));

        // fifth instruction faults
        base = retired_cnt;
        base_flush = flush_cnt;
        fault_pc = 32'h0000_1000 + xlen_t'((pc_seq + 4) * 4);
        send_insns(8);
        complete_pending(8, 1'b1, fault_pc);
        wait_drained();
        repeat (2) @(negedge clk);
        assert (flush_cnt - base_flush == 1 && epc == fault_pc && outstanding == 0)
            else report_mismatch($sformatf("%0d flushes, epc %h, expected %h",
                flush_cnt - base_flush, epc, fault_pc));
        assert (retired_cnt - base == 4)
            else report_mismatch($sformatf("%0d of 4 older retired", retired_cnt - base));
        base = retired_cnt;
        send_insns(4);
        complete_pending(4, 1'b0, '0);
        wait_drained();
        assert (retired_cnt - base == 4)
            else report_mismatch($sformatf("%0d of 4 retired after flush", retired_cnt - base));

        repeat (4) @(negedge clk);
        $display("checks done: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
